//--- id_stage.f
hdl/riscv_isa_pkg.sv
hdl/id_ctrl_pkg.sv
hdl/id_if.sv
hdl/id_decoder.sv
hdl/id_operand_gather.sv
hdl/id_ex_pipe.sv
hdl/id_stage.sv
tests/id_stage_assert.sv
tests/id_stage_tb.sv

//--- Makefile
# Verilator flow for the decode stage
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= id_stage.f
TB_TOP    ?= id_stage_tb
RTL_TOP   ?= id_stage
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/id_stage_tb.sv
/*
 * Table-driven testbench for the decode stage.
 * Each row encodes one instruction, drives it through the ID/EX handshake
 * under random EX back-pressure and checks the registered outputs.
 */
module id_stage_tb;
  import riscv_isa_pkg::*;
  import id_ctrl_pkg::*;

  localparam int TIMEOUT = 50;
  localparam word_t WDATA_EX = 32'hE0E0_1234;

  // Operand source codes: a 0 rs1 1 pc 2 zero 3 skip, b 0 rs2 1 imm 2 four 3 skip
  // c 0 skip 1 rs2 2 pc+imm, jump 0 skip 1 pc+imm 2 rs1+imm
  typedef struct {
    string    name;
    word_t    instr;
    word_t    pc;
    fwd_sel_e fa;
    fwd_sel_e fb;
    word_t    imm;
    alu_op_e  op;
    logic [6:0] flags;  // alu_en lsu_en lsu_we rf_we bch jmp illegal
    int       a_src;
    int       b_src;
    int       c_src;
    int       j_src;
  } row_t;

  logic clk = 1'b0;
  logic rst_n, instr_valid_i, kill_id_i, halt_id_i, ex_ready_i;
  word_t instr_i, pc_i, rf_rdata_a_i, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i;
  word_t jmp_target_o, ex_operand_a_o, ex_operand_b_o, ex_operand_c_o, ex_pc_o;
  fwd_sel_e fwd_sel_a_i, fwd_sel_b_i;
  rf_addr_t rf_raddr_a_o, rf_raddr_b_o, ex_rf_waddr_o;
  logic id_ready_o, id_valid_o, ex_valid_o, ex_alu_en_o, ex_alu_bch_o, ex_alu_jmp_o;
  logic ex_lsu_en_o, ex_lsu_we_o, ex_rf_we_o, ex_illegal_o;
  alu_op_e ex_alu_op_o;

  word_t regs [32];
  row_t  rows [$];
  int    n_err = 0;
  int    row_err;
  logic  timed_out = 1'b0;

  id_stage DUT (.*);

  always #5 clk = ~clk;

  // Register file model, read in the same cycle
  assign rf_rdata_a_i = regs[rf_raddr_a_o];
  assign rf_rdata_b_i = regs[rf_raddr_b_o];

  ////////////////////////////////////////////////////////////
  // Instruction encoders, immediate given as its value
  ////////////////////////////////////////////////////////////

  function automatic word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
  endfunction

  function automatic word_t enc_i(word_t imm, int rs1, logic [2:0] f3, int rd,
                                  logic [6:0] opc);
    return {imm[11:0], 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic word_t enc_s(word_t imm, int rs2, int rs1);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(word_t imm, int rs2, int rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t enc_j(word_t imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'b1101111};
  endfunction

  // Expected rs value after bypass
  function automatic word_t source_value(fwd_sel_e sel, word_t rf_val);
    if (sel == SEL_FW_EX) return WDATA_EX;
    if (sel == SEL_FW_WB) return rf_wdata_wb_i;
    return rf_val;
  endfunction

  task automatic add(string name, word_t instr, word_t pc, fwd_sel_e fa, fwd_sel_e fb,
                     word_t imm, alu_op_e op, logic [6:0] flags, int a, int b, int c, int j);
    row_t r;
    r = '{name, instr, pc, fa, fb, imm, op, flags, a, b, c, j};
    rows.push_back(r);
  endtask

  task automatic check_word(string sig, word_t got, word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, sig, exp, got);
      n_err++;
      row_err++;
    end
  endtask

  task automatic check_bit(string sig, logic got, logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED t=%0t %s expected %b got %b", $time, sig, exp, got);
      n_err++;
      row_err++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Handshake waits
  ////////////////////////////////////////////////////////////

  // Returns at the negedge before the transfer edge
  task automatic wait_transfer(output logic ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < TIMEOUT) begin
      @(negedge clk);
      if (id_valid_o && ex_ready_i) begin
        ok = 1'b1;
      end else begin
        @(posedge clk);
        ex_ready_i <= ($urandom % 4) != 0;
        n++;
      end
    end
  endtask

  task automatic wait_ex_valid(output logic ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < TIMEOUT) begin
      @(negedge clk);
      if (ex_valid_o) ok = 1'b1;
      else @(posedge clk);
      n++;
    end
  endtask

  task automatic run_row(int idx);
    row_t  r;
    logic  ok;
    word_t rs1v, rs2v, exp;
    r = rows[idx];
    row_err = 0;
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= r.instr;
    pc_i          <= r.pc;
    fwd_sel_a_i   <= r.fa;
    fwd_sel_b_i   <= r.fb;
    ex_ready_i    <= ($urandom % 4) != 0;
    wait_transfer(ok);
    if (!ok) begin
      $display("Timeout: test %0d %s was never accepted", idx, r.name);
      timed_out = 1'b1;
    end else begin
      rs1v = source_value(r.fa, regs[r.instr[19:15]]);
      rs2v = source_value(r.fb, regs[r.instr[24:20]]);
      // Register file addresses come from the rs1 and rs2 fields
      check_word("rf_raddr_a_o", 32'(rf_raddr_a_o), 32'(r.instr[19:15]));
      check_word("rf_raddr_b_o", 32'(rf_raddr_b_o), 32'(r.instr[24:20]));
      // Jump target is combinational before the transfer
      if (r.j_src == 1) check_word("jmp_target_o", jmp_target_o, r.pc + r.imm);
      if (r.j_src == 2) check_word("jmp_target_o", jmp_target_o, (rs1v + r.imm) & ~32'd1);
      @(posedge clk);
      instr_valid_i <= 1'b0;
      ex_ready_i    <= ($urandom % 4) != 0;
      wait_ex_valid(ok);
      if (!ok) begin
        $display("Timeout: test %0d %s never reached EX", idx, r.name);
        timed_out = 1'b1;
      end else begin
        check_bit("ex_alu_en_o", ex_alu_en_o, r.flags[6]);
        check_bit("ex_lsu_en_o", ex_lsu_en_o, r.flags[5]);
        check_bit("ex_lsu_we_o", ex_lsu_we_o, r.flags[4]);
        check_bit("ex_rf_we_o", ex_rf_we_o, r.flags[3]);
        check_bit("ex_alu_bch_o", ex_alu_bch_o, r.flags[2]);
        check_bit("ex_alu_jmp_o", ex_alu_jmp_o, r.flags[1]);
        check_bit("ex_illegal_o", ex_illegal_o, r.flags[0]);
        check_word("ex_pc_o", ex_pc_o, r.pc);
        if (!r.flags[0]) check_word("ex_alu_op_o", 32'(ex_alu_op_o), 32'(r.op));
        if (r.flags[3]) check_word("ex_rf_waddr_o", 32'(ex_rf_waddr_o), 32'(r.instr[11:7]));
        // Operand A
        if (r.a_src < 3) begin
          exp = (r.a_src == 0) ? rs1v : (r.a_src == 1) ? r.pc : 32'd0;
          check_word("ex_operand_a_o", ex_operand_a_o, exp);
        end
        // Operand B
        if (r.b_src < 3) begin
          exp = (r.b_src == 0) ? rs2v : (r.b_src == 1) ? r.imm : 32'd4;
          check_word("ex_operand_b_o", ex_operand_b_o, exp);
        end
        // Operand C, store data or branch target
        if (r.c_src == 1) check_word("ex_operand_c_o", ex_operand_c_o, rs2v);
        if (r.c_src == 2) check_word("ex_operand_c_o", ex_operand_c_o, r.pc + r.imm);
        // Fetch offers nothing now, so the row cannot transfer a second time
        check_bit("id_valid_o", id_valid_o, 1'b0);
        check_bit("id_ready_o", id_ready_o, ex_ready_i);
      end
    end
    $display("test %0d %s: %s", idx, r.name, (row_err == 0 && ok) ? "ok" : "mismatch");
  endtask

  // Halt or kill with EX ready, nothing may transfer
  task automatic run_blocked(string name, logic halt, logic kill);
    row_err = 0;
    @(posedge clk);
    instr_valid_i <= 1'b1;
    instr_i       <= rows[0].instr;
    halt_id_i     <= halt;
    kill_id_i     <= kill;
    ex_ready_i    <= 1'b1;
    @(negedge clk);
    check_bit("id_valid_o", id_valid_o, 1'b0);
    check_bit("id_ready_o", id_ready_o, kill);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    @(posedge clk);
    instr_valid_i <= 1'b0;
    halt_id_i     <= 1'b0;
    kill_id_i     <= 1'b0;
    $display("test %s: %s", name, (row_err == 0) ? "ok" : "mismatch");
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(33));
    foreach (regs[i]) regs[i] = $urandom;
    rf_wdata_wb_i = $urandom;
    rf_wdata_ex_i = WDATA_EX;
    rst_n = 1'b0;
    instr_valid_i = 1'b0;
    kill_id_i = 1'b0;
    halt_id_i = 1'b0;
    ex_ready_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    fwd_sel_a_i = SEL_REGFILE;
    fwd_sel_b_i = SEL_REGFILE;

    add("add", enc_r(7'h00, 2, 1, 3'b000, 5), 32'h10, SEL_REGFILE, SEL_REGFILE, 0,
        ALU_ADD, 7'b1001000, 0, 0, 0, 0);
    add("sub", enc_r(7'h20, 4, 3, 3'b000, 6), 32'h14, SEL_REGFILE, SEL_REGFILE, 0,
        ALU_SUB, 7'b1001000, 0, 0, 0, 0);
    add("sra", enc_r(7'h20, 9, 8, 3'b101, 7), 32'h18, SEL_REGFILE, SEL_REGFILE, 0,
        ALU_SRA, 7'b1001000, 0, 0, 0, 0);
    add("sltu", enc_r(7'h00, 11, 10, 3'b011, 12), 32'h1c, SEL_REGFILE, SEL_REGFILE, 0,
        ALU_SLTU, 7'b1001000, 0, 0, 0, 0);
    add("addi", enc_i(-32'sd5, 10, 3'b000, 11, 7'b0010011), 32'h20, SEL_REGFILE,
        SEL_REGFILE, -32'sd5, ALU_ADD, 7'b1001000, 0, 1, 0, 0);
    add("lui", {20'hABCDE, 5'd12, 7'b0110111}, 32'h24, SEL_REGFILE, SEL_REGFILE,
        32'hABCDE000, ALU_ADD, 7'b1001000, 2, 1, 0, 0);
    add("auipc", {20'h12345, 5'd13, 7'b0010111}, 32'h100, SEL_REGFILE, SEL_REGFILE,
        32'h12345000, ALU_ADD, 7'b1001000, 1, 1, 0, 0);
    add("lw", enc_i(32'd16, 13, 3'b010, 14, 7'b0000011), 32'h104, SEL_REGFILE,
        SEL_REGFILE, 32'd16, ALU_ADD, 7'b0101000, 0, 1, 0, 0);
    add("sw", enc_s(-32'sd8, 15, 16), 32'h108, SEL_REGFILE, SEL_REGFILE, -32'sd8,
        ALU_ADD, 7'b0110000, 0, 1, 1, 0);
    add("add_fwd", enc_r(7'h00, 2, 1, 3'b000, 5), 32'h10c, SEL_FW_EX, SEL_FW_WB, 0,
        ALU_ADD, 7'b1001000, 0, 0, 0, 0);
    add("sw_fwd", enc_s(32'd4, 15, 16), 32'h110, SEL_FW_WB, SEL_FW_EX, 32'd4,
        ALU_ADD, 7'b0110000, 0, 1, 1, 0);
    add("jal", enc_j(32'h800, 1), 32'h200, SEL_REGFILE, SEL_REGFILE, 32'h800,
        ALU_ADD, 7'b1001010, 1, 2, 0, 1);
    add("jalr", enc_i(32'h15, 17, 3'b000, 1, 7'b1100111), 32'h204, SEL_REGFILE,
        SEL_REGFILE, 32'h15, ALU_ADD, 7'b1001010, 1, 2, 0, 2);
    add("jalr_fwd", enc_i(32'h21, 17, 3'b000, 1, 7'b1100111), 32'h208, SEL_FW_WB,
        SEL_REGFILE, 32'h21, ALU_ADD, 7'b1001010, 1, 2, 0, 2);
    add("beq", enc_b(32'h40, 19, 18, 3'b000), 32'h300, SEL_REGFILE, SEL_REGFILE,
        32'h40, ALU_EQ, 7'b1000100, 0, 0, 2, 0);
    add("bgeu", enc_b(-32'sd16, 21, 20, 3'b111), 32'h304, SEL_FW_EX, SEL_REGFILE,
        -32'sd16, ALU_GEU, 7'b1000100, 0, 0, 2, 0);
    add("bad_opc", 32'h0000_007F, 32'h308, SEL_REGFILE, SEL_REGFILE, 0,
        ALU_ADD, 7'b0000001, 3, 3, 0, 0);
    add("bad_f7", enc_r(7'h01, 2, 1, 3'b000, 5), 32'h30c, SEL_REGFILE, SEL_REGFILE, 0,
        ALU_ADD, 7'b0000001, 3, 3, 0, 0);

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < rows.size() && !timed_out; i++) begin
      run_row(i);
    end
    if (!timed_out) begin
      run_blocked("halt", 1'b1, 1'b0);
      run_blocked("kill", 1'b0, 1'b1);
    end

    $display("rows %0d, failing checks %0d, timeout %0d", rows.size(), n_err, timed_out);
    if (n_err == 0 && !timed_out) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- tests/id_stage_assert.sv
/*
 * Concurrent checks on the decode stage handshake and reset.
 * Bound into every id_stage instance from the testbench file list.
 */
module id_stage_assert (
  input logic        clk,
  input logic        rst_n,
  input logic        kill_id_i,
  input logic        ex_ready_i,
  input logic        ex_valid_o,
  input logic        ex_alu_en_o,
  input logic        ex_alu_bch_o,
  input logic        ex_alu_jmp_o,
  input logic [3:0]  ex_alu_op_o,
  input logic [31:0] ex_operand_a_o,
  input logic [31:0] ex_operand_b_o,
  input logic [31:0] ex_operand_c_o,
  input logic [31:0] ex_pc_o,
  input logic        ex_lsu_en_o,
  input logic        ex_lsu_we_o,
  input logic        ex_rf_we_o,
  input logic        ex_illegal_o,
  input logic [4:0]  ex_rf_waddr_o
);

  // EX stalls, so the ID/EX register must hold
  hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid_o && !ex_ready_i) |=>
      $stable({ex_valid_o, ex_alu_en_o, ex_alu_bch_o, ex_alu_jmp_o, ex_alu_op_o,
               ex_operand_a_o, ex_operand_b_o, ex_operand_c_o, ex_pc_o,
               ex_lsu_en_o, ex_lsu_we_o, ex_rf_we_o, ex_illegal_o, ex_rf_waddr_o}))
    else $error("ID/EX outputs changed under back-pressure");

  // A killed instruction never reaches EX
  no_transfer_on_kill: assert property (@(posedge clk) disable iff (!rst_n)
    (kill_id_i && ex_ready_i) |=> !ex_valid_o)
    else $error("ex_valid_o high after a killed instruction");

  // Register comes out of reset empty
  empty_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !ex_valid_o)
    else $error("ex_valid_o high right after reset");

endmodule

bind id_stage id_stage_assert u_assert (.*);

//--- hdl/id_stage.sv
/*
 * RV32I instruction decode stage, top level.
 * Decoder and operand gatherer work side by side on the fetched word;
 * the ID/EX pipe combines their results and talks to fetch and EX.
 */
module id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  // From fetch
  input  logic                    instr_valid_i,
  input  riscv_isa_pkg::word_t    instr_i,
  input  riscv_isa_pkg::word_t    pc_i,
  input  logic                    kill_id_i,
  input  logic                    halt_id_i,
  // Register file read ports
  input  riscv_isa_pkg::word_t    rf_rdata_a_i,
  input  riscv_isa_pkg::word_t    rf_rdata_b_i,
  output riscv_isa_pkg::rf_addr_t rf_raddr_a_o,
  output riscv_isa_pkg::rf_addr_t rf_raddr_b_o,
  // Bypass data and selects
  input  riscv_isa_pkg::word_t    rf_wdata_ex_i,
  input  riscv_isa_pkg::word_t    rf_wdata_wb_i,
  input  id_ctrl_pkg::fwd_sel_e   fwd_sel_a_i,
  input  id_ctrl_pkg::fwd_sel_e   fwd_sel_b_i,
  // Handshake and jump target
  input  logic                    ex_ready_i,
  output logic                    id_ready_o,
  output logic                    id_valid_o,
  output riscv_isa_pkg::word_t    jmp_target_o,
  // ID/EX register outputs
  output logic                    ex_valid_o,
  output logic                    ex_alu_en_o,
  output logic                    ex_alu_bch_o,
  output logic                    ex_alu_jmp_o,
  output id_ctrl_pkg::alu_op_e    ex_alu_op_o,
  output riscv_isa_pkg::word_t    ex_operand_a_o,
  output riscv_isa_pkg::word_t    ex_operand_b_o,
  output riscv_isa_pkg::word_t    ex_operand_c_o,
  output riscv_isa_pkg::word_t    ex_pc_o,
  output logic                    ex_lsu_en_o,
  output logic                    ex_lsu_we_o,
  output logic                    ex_rf_we_o,
  output logic                    ex_illegal_o,
  output riscv_isa_pkg::rf_addr_t ex_rf_waddr_o
);

  // Internal bundles, named after the submodule ports they bind to
  id_ctrl_if ctrl ();
  id_opnd_if opnd ();

  // Control fields from the instruction word
  id_decoder u_decoder (.*);

  // Addresses, immediates, forwarding and targets
  id_operand_gather u_gather (.*);

  // Operand select, handshake and ID/EX register
  id_ex_pipe u_pipe (.*);

endmodule

//--- hdl/id_ex_pipe.sv
/*
 * Final operand selection and the ID/EX pipeline register.
 * Computes the ID valid/ready handshake and captures one instruction per
 * transfer. Under EX back-pressure every registered output holds.
 */
module id_ex_pipe (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    instr_valid_i,
  input  logic                    kill_id_i,
  input  logic                    halt_id_i,
  input  logic                    ex_ready_i,
  input  riscv_isa_pkg::word_t    pc_i,
  id_ctrl_if.pipe                 ctrl,
  id_opnd_if.pipe                 opnd,
  output logic                    id_ready_o,
  output logic                    id_valid_o,
  output riscv_isa_pkg::word_t    jmp_target_o,
  output logic                    ex_valid_o,
  output logic                    ex_alu_en_o,
  output logic                    ex_alu_bch_o,
  output logic                    ex_alu_jmp_o,
  output id_ctrl_pkg::alu_op_e    ex_alu_op_o,
  output riscv_isa_pkg::word_t    ex_operand_a_o,
  output riscv_isa_pkg::word_t    ex_operand_b_o,
  output riscv_isa_pkg::word_t    ex_operand_c_o,
  output riscv_isa_pkg::word_t    ex_pc_o,
  output logic                    ex_lsu_en_o,
  output logic                    ex_lsu_we_o,
  output logic                    ex_rf_we_o,
  output logic                    ex_illegal_o,
  output riscv_isa_pkg::rf_addr_t ex_rf_waddr_o
);
  import riscv_isa_pkg::*;
  import id_ctrl_pkg::*;

  word_t operand_a;
  word_t operand_b;
  word_t operand_c;
  word_t imm_b;
  logic  transfer;
  logic  op_c_used;

  ////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////

  always_comb begin : operand_mux
    case (ctrl.op_a_sel)
      OP_A_PC:   operand_a = pc_i;
      OP_A_ZERO: operand_a = '0;
      default:   operand_a = opnd.rs1_fw;
    endcase
    case (ctrl.imm_sel)
      IMM_S:   imm_b = opnd.imm_s;
      IMM_U:   imm_b = opnd.imm_u;
      default: imm_b = opnd.imm_i;
    endcase
    case (ctrl.op_b_sel)
      OP_B_IMM:    operand_b = imm_b;
      OP_B_PCINCR: operand_b = PC_INCR;
      default:     operand_b = opnd.rs2_fw;
    endcase
    // Store data or branch target
    operand_c = (ctrl.op_c_sel == OP_C_BCH_TARGET) ? opnd.bch_target : opnd.rs2_fw;
  end

  assign jmp_target_o = (ctrl.jmp_sel == JMP_JALR) ? opnd.jalr_target : opnd.jal_target;

  // Operand C only matters for stores and branches
  assign op_c_used = ctrl.lsu_we || ctrl.alu_bch;

  // Stage handshake, kill drains ID regardless of EX
  assign id_valid_o = instr_valid_i && !kill_id_i && !halt_id_i;
  assign id_ready_o = kill_id_i || (ex_ready_i && !halt_id_i);
  assign transfer   = id_valid_o && ex_ready_i;

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin : id_ex_regs
    if (!rst_n) begin
      ex_valid_o     <= 1'b0;
      ex_alu_en_o    <= 1'b0;
      ex_alu_bch_o   <= 1'b0;
      ex_alu_jmp_o   <= 1'b0;
      ex_alu_op_o    <= ALU_ADD;
      ex_operand_a_o <= '0;
      ex_operand_b_o <= '0;
      ex_operand_c_o <= '0;
      ex_pc_o        <= '0;
      ex_lsu_en_o    <= 1'b0;
      ex_lsu_we_o    <= 1'b0;
      ex_rf_we_o     <= 1'b0;
      ex_illegal_o   <= 1'b0;
      ex_rf_waddr_o  <= '0;
    end else if (transfer) begin
      ex_valid_o     <= 1'b1;
      ex_alu_en_o    <= ctrl.alu_en;
      ex_alu_bch_o   <= ctrl.alu_bch;
      ex_alu_jmp_o   <= ctrl.alu_jmp;
      ex_alu_op_o    <= ctrl.alu_op;
      ex_operand_a_o <= operand_a;
      ex_operand_b_o <= operand_b;
      ex_pc_o        <= pc_i;
      ex_lsu_en_o    <= ctrl.lsu_en;
      ex_lsu_we_o    <= ctrl.lsu_we;
      ex_rf_we_o     <= ctrl.rf_we;
      ex_illegal_o   <= ctrl.illegal;
      // Idle fields keep their old value to save toggling
      if (op_c_used) begin
        ex_operand_c_o <= operand_c;
      end
      if (ctrl.rf_we) begin
        ex_rf_waddr_o <= opnd.rf_waddr;
      end
    end else if (ex_ready_i) begin
      // EX consumed its instruction and nothing new came in
      ex_valid_o <= 1'b0;
    end
  end

endmodule

//--- hdl/id_operand_gather.sv
/*
 * Operand gathering for the decode stage, purely combinational.
 * Slices register addresses, builds immediates, applies rs1/rs2
 * forwarding and adds the branch and jump targets.
 */
module id_operand_gather (
  input  riscv_isa_pkg::word_t    instr_i,
  input  riscv_isa_pkg::word_t    pc_i,
  input  riscv_isa_pkg::word_t    rf_rdata_a_i,
  input  riscv_isa_pkg::word_t    rf_rdata_b_i,
  input  riscv_isa_pkg::word_t    rf_wdata_ex_i,
  input  riscv_isa_pkg::word_t    rf_wdata_wb_i,
  input  id_ctrl_pkg::fwd_sel_e   fwd_sel_a_i,
  input  id_ctrl_pkg::fwd_sel_e   fwd_sel_b_i,
  output riscv_isa_pkg::rf_addr_t rf_raddr_a_o,
  output riscv_isa_pkg::rf_addr_t rf_raddr_b_o,
  id_opnd_if.src                  opnd
);
  import riscv_isa_pkg::*;
  import id_ctrl_pkg::*;

  word_t imm_b;
  word_t imm_j;
  word_t jalr_sum;

  // One forwarding mux, used for both source registers
  function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf, word_t ex, word_t wb);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  // Register addresses, read speculatively for every format
  assign rf_raddr_a_o  = instr_i[RS1_LSB +: REG_AW];
  assign rf_raddr_b_o  = instr_i[RS2_LSB +: REG_AW];
  assign opnd.rf_waddr = instr_i[RD_LSB +: REG_AW];

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  assign opnd.imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign opnd.imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign opnd.imm_u = {instr_i[31:12], 12'b0};
  // B and J forms are halfword offsets with scrambled bits
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  // rs1/rs2 with EX or WB bypass
  assign opnd.rs1_fw = fwd_mux(fwd_sel_a_i, rf_rdata_a_i, rf_wdata_ex_i, rf_wdata_wb_i);
  assign opnd.rs2_fw = fwd_mux(fwd_sel_b_i, rf_rdata_b_i, rf_wdata_ex_i, rf_wdata_wb_i);

  ////////////////////////////////////////////////////////////
  // Targets
  ////////////////////////////////////////////////////////////

  assign opnd.bch_target = pc_i + imm_b;
  assign opnd.jal_target = pc_i + imm_j;
  // JALR uses the forwarded rs1 and drops bit 0
  assign jalr_sum         = opnd.rs1_fw + opnd.imm_i;
  assign opnd.jalr_target = {jalr_sum[XLEN-1:1], 1'b0};

endmodule

//--- hdl/id_decoder.sv
/*
 * RV32I base decoder, purely combinational.
 * Maps opcode, funct3 and funct7 onto ALU operation, mux selects and
 * unit enables. Unsupported encodings raise illegal with all enables low.
 */
module id_decoder (
  input  riscv_isa_pkg::word_t instr_i,
  id_ctrl_if.dec               ctrl
);
  import riscv_isa_pkg::*;
  import id_ctrl_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  alu_op_e    arith_op;
  logic       arith_bad;
  logic       illegal;

  assign opcode  = opcode_e'(instr_i[OPCODE_W-1:0]);
  assign funct3  = instr_i[FUNCT3_LSB +: 3];
  assign funct7  = instr_i[FUNCT7_LSB +: 7];
  assign f7_zero = (funct7 == 7'b0);
  assign f7_alt  = (funct7 == FUNCT7_ALT);

  ////////////////////////////////////////////////////////////
  // Arithmetic group, shared by OP and OP_IMM
  ////////////////////////////////////////////////////////////

  always_comb begin : arith_decode
    case (funct3)
      // ADDI has no SUB form, funct7 is immediate there
      3'b000:  arith_op = (opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = f7_alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin : arith_check
    if (opcode == OPC_OP) begin
      // Alternate funct7 only exists for SUB and SRA
      arith_bad = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
    end else begin
      // Only the shift immediates constrain the upper bits
      case (funct3)
        3'b001:  arith_bad = !f7_zero;
        3'b101:  arith_bad = !(f7_zero || f7_alt);
        default: arith_bad = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Main opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin : main_decode
    ctrl.alu_en   = 1'b0;
    ctrl.alu_op   = ALU_ADD;
    ctrl.alu_bch  = 1'b0;
    ctrl.alu_jmp  = 1'b0;
    ctrl.op_a_sel = OP_A_RS1;
    ctrl.op_b_sel = OP_B_RS2;
    ctrl.op_c_sel = OP_C_RS2;
    ctrl.imm_sel  = IMM_I;
    ctrl.jmp_sel  = JMP_JAL;
    ctrl.lsu_en   = 1'b0;
    ctrl.lsu_we   = 1'b0;
    ctrl.rf_we    = 1'b0;
    illegal       = 1'b0;

    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        ctrl.alu_en   = 1'b1;
        ctrl.alu_op   = arith_op;
        ctrl.rf_we    = 1'b1;
        ctrl.op_b_sel = (opcode == OPC_OP) ? OP_B_RS2 : OP_B_IMM;
        illegal       = arith_bad;
      end
      OPC_LUI, OPC_AUIPC: begin
        // Upper immediate added to zero or to PC
        ctrl.alu_en   = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.op_a_sel = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
      end
      OPC_JAL, OPC_JALR: begin
        // ALU forms the link value PC + 4
        ctrl.alu_en   = 1'b1;
        ctrl.alu_jmp  = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_PCINCR;
        ctrl.jmp_sel  = (opcode == OPC_JAL) ? JMP_JAL : JMP_JALR;
        illegal       = (opcode == OPC_JALR) && (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        ctrl.alu_en   = 1'b1;
        ctrl.alu_bch  = 1'b1;
        ctrl.op_c_sel = OP_C_BCH_TARGET;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: illegal     = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        // LB LH LW LBU LHU
        ctrl.lsu_en   = 1'b1;
        ctrl.rf_we    = 1'b1;
        ctrl.op_b_sel = OP_B_IMM;
        illegal       = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OPC_STORE: begin
        // Store data travels on operand C
        ctrl.lsu_en   = 1'b1;
        ctrl.lsu_we   = 1'b1;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_S;
        illegal       = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: illegal = 1'b1;
    endcase

    // Nothing of an illegal instruction may reach a unit
    if (illegal) begin
      ctrl.alu_en = 1'b0;
      ctrl.lsu_en = 1'b0;
      ctrl.rf_we  = 1'b0;
    end
    ctrl.illegal = illegal;
  end

endmodule

//--- hdl/id_if.sv
/*
 * Internal bundles of the decode stage.
 * id_ctrl_if carries decoder control fields into the ID/EX pipe,
 * id_opnd_if carries gathered operands, immediates and targets.
 */

interface id_ctrl_if;
  import id_ctrl_pkg::*;

  // ALU
  logic      alu_en;
  alu_op_e   alu_op;
  logic      alu_bch;
  logic      alu_jmp;
  // Operand and target selects
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  op_c_sel_e op_c_sel;
  imm_sel_e  imm_sel;
  jmp_sel_e  jmp_sel;
  // LSU and write-back
  logic      lsu_en;
  logic      lsu_we;
  logic      rf_we;
  logic      illegal;

  modport dec (
    output alu_en, alu_op, alu_bch, alu_jmp, op_a_sel, op_b_sel, op_c_sel,
    output imm_sel, jmp_sel, lsu_en, lsu_we, rf_we, illegal
  );

  modport pipe (
    input alu_en, alu_op, alu_bch, alu_jmp, op_a_sel, op_b_sel, op_c_sel,
    input imm_sel, jmp_sel, lsu_en, lsu_we, rf_we, illegal
  );
endinterface

interface id_opnd_if;
  import riscv_isa_pkg::*;

  // Register operands after forwarding
  word_t    rs1_fw;
  word_t    rs2_fw;
  // Sign-extended immediates for operand B
  word_t    imm_i;
  word_t    imm_s;
  word_t    imm_u;
  // Precomputed targets
  word_t    bch_target;
  word_t    jal_target;
  word_t    jalr_target;
  rf_addr_t rf_waddr;

  modport src (
    output rs1_fw, rs2_fw, imm_i, imm_s, imm_u, bch_target, jal_target, jalr_target, rf_waddr
  );

  modport pipe (
    input rs1_fw, rs2_fw, imm_i, imm_s, imm_u, bch_target, jal_target, jalr_target, rf_waddr
  );
endinterface

//--- hdl/id_ctrl_pkg.sv
/*
 * Control encodings produced by the decoder and consumed by the ID/EX pipe.
 * ALU operations, operand mux selects and forwarding selects.
 */
package id_ctrl_pkg;

  // ALU operation, arithmetic first and branch compares last
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {OP_A_RS1, OP_A_PC, OP_A_ZERO} op_a_sel_e;

  // Operand B source, PCINCR is the link value for jumps
  typedef enum logic [1:0] {OP_B_RS2, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;

  // Operand C carries store data or the branch target
  typedef enum logic {OP_C_RS2, OP_C_BCH_TARGET} op_c_sel_e;

  // Immediate routed to operand B
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U} imm_sel_e;

  // Jump target source
  typedef enum logic {JMP_JAL, JMP_JALR} jmp_sel_e;

  // rs1/rs2 value source, supplied by the hazard logic outside ID
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fwd_sel_e;

endpackage

//--- hdl/riscv_isa_pkg.sv
/*
 * RV32I instruction-set facts shared by the decode stage.
 * Word and register index types, major opcodes and field positions.
 * Import where instruction words are sliced or decoded.
 */
package riscv_isa_pkg;

  // Data and address width
  localparam int XLEN   = 32;
  // Register index width, 32 architectural registers
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] rf_addr_t;

  // Field positions inside the instruction word
  localparam int OPCODE_W   = 7;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;

  // funct7 pattern of SUB and SRA/SRAI
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  // Link value added to PC for JAL and JALR
  localparam word_t PC_INCR = 32'd4;

  // Major opcodes of the supported base formats
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

endpackage
